//--- include/psram_macros.svh
/* PSRAM controller constants
   Command codes, field widths, phase lengths and the default power-up delay */
`ifndef PSRAM_MACROS_SVH
`define PSRAM_MACROS_SVH

// SPI init commands
`define PSRAM_CMD_RSTEN      8'h66
`define PSRAM_CMD_RST        8'h99
`define PSRAM_CMD_QPI_EN     8'h35

// QPI access commands
`define PSRAM_CMD_QREAD      8'hEB
`define PSRAM_CMD_QWRITE     8'h38

// Field widths
`define PSRAM_ADDR_W         24
`define PSRAM_DATA_W         16

// Phase lengths in mem_clk cycles
`define PSRAM_SPI_BITS       8
`define PSRAM_CMD_NIBBLES    2
`define PSRAM_ADDR_NIBBLES   6
`define PSRAM_DATA_NIBBLES   4
`define PSRAM_WAIT_CYCLES    6

// About 150 us at 84 MHz
`define PSRAM_PWRUP_DEFAULT  12800

`endif

//--- hw/psram_pkg.sv
/* PSRAM controller types
   Transfer kinds, sequencer states and shifter phases */
`default_nettype none

package psram_pkg;

	// Kind of transfer on the PSRAM pins
	typedef enum logic [1:0] {
		OP_NONE,
		OP_SPI_CMD,
		OP_QREAD,
		OP_QWRITE
	} psram_op_e;

	// Sequencer states, init first then QPI access
	typedef enum logic [3:0] {
		ST_PWRUP,
		ST_RSTEN,
		ST_RST,
		ST_QPI_EN,
		ST_IDLE,
		ST_CMD,
		ST_ADDR,
		ST_WAIT,
		ST_DATA,
		ST_DONE
	} ctrl_state_e;

	// What the shifter does this cycle
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SPI,
		PH_CMD,
		PH_ADDR,
		PH_WAIT,
		PH_WDATA,
		PH_RDATA
	} phase_e;

endpackage

`default_nettype wire

//--- hw/psram_cycle_timer.sv
/* Phase timer
   Loadable 16-bit down-counter, starts at the power-up delay and stops at zero */
`timescale 1ns/1ps
`default_nettype none
`include "psram_macros.svh"

module psram_cycle_timer #(
	parameter int unsigned POWERUP_CYCLES = `PSRAM_PWRUP_DEFAULT
) (
	input  wire         mem_clk,
	input  wire         rst_n,
	input  wire         timer_load,
	input  wire  [15:0] timer_count,
	output logic        timer_zero
);

	logic [15:0] count;

	always_ff @(posedge mem_clk or negedge rst_n) begin
		if (!rst_n) begin
			// Power-up delay runs right out of reset
			count <= 16'(POWERUP_CYCLES);
		end else if (timer_load) begin
			count <= timer_count;
		end else if (count != 16'd0) begin
			count <= count - 16'd1;
		end
	end

	// Phase ends on the cycle this is seen
	assign timer_zero = (count == 16'd0);

endmodule

`default_nettype wire

//--- hw/psram_shifter.sv
/* PSRAM pin shifter
   Drives command, address and write data on sio and collects read nibbles */
`timescale 1ns/1ps
`default_nettype none
`include "psram_macros.svh"

module psram_shifter (
	input  wire                      mem_clk,
	input  wire                      rst_n,
	input  wire psram_pkg::phase_e   phase,
	input  wire psram_pkg::psram_op_e op,
	input  wire  [7:0]               cmd_byte,
	input  wire                      shift_load,
	input  wire  [`PSRAM_ADDR_W-1:0] req_addr,
	input  wire  [`PSRAM_DATA_W-1:0] req_wdata,
	output logic                     mem_ce_n,
	output logic [3:0]               sio_out,
	output logic                     sio_oe,
	input  wire  [3:0]               sio_in,
	output logic [`PSRAM_DATA_W-1:0] rdata_word
);
	import psram_pkg::*;

	// Command, address, write data
	localparam int SHIFT_W = 8 + `PSRAM_ADDR_W + `PSRAM_DATA_W;

	logic [SHIFT_W-1:0] shift_q;
	logic [SHIFT_W-1:0] shift_word;

	// Fields not used by this op stay zero
	always_comb begin
		shift_word = {cmd_byte, {(SHIFT_W - 8){1'b0}}};
		if ((op == OP_QREAD) || (op == OP_QWRITE)) begin
			shift_word[`PSRAM_DATA_W +: `PSRAM_ADDR_W] = req_addr;
		end
		if (op == OP_QWRITE) begin
			shift_word[`PSRAM_DATA_W-1:0] = req_wdata;
		end
	end

	// CE low for the whole transfer
	assign mem_ce_n = (phase == PH_IDLE);
	// Memory owns the bus from the first wait cycle
	assign sio_oe = (phase == PH_SPI) || (phase == PH_CMD) ||
			(phase == PH_ADDR) || (phase == PH_WDATA);
	// SPI uses sio[0] only
	assign sio_out = (phase == PH_SPI) ? {3'b000, shift_q[SHIFT_W-1]} :
			shift_q[SHIFT_W-1 -: 4];

	always_ff @(posedge mem_clk or negedge rst_n) begin
		if (!rst_n) begin
			shift_q <= '0;
		end else if (shift_load) begin
			shift_q <= shift_word;
		end else if (phase == PH_SPI) begin
			// One bit per cycle, MSB first
			shift_q <= {shift_q[SHIFT_W-2:0], 1'b0};
		end else if (sio_oe) begin
			// One nibble per cycle
			shift_q <= {shift_q[SHIFT_W-5:0], 4'b0000};
		end
	end

	// Read nibbles, MSB first, sampled at the end of each data cycle
	always_ff @(posedge mem_clk) begin
		if (phase == PH_RDATA) begin
			rdata_word <= {rdata_word[`PSRAM_DATA_W-5:0], sio_in};
		end
	end

endmodule

`default_nettype wire

//--- hw/psram_sequencer.sv
/* PSRAM sequencer
   Power-up wait, the three SPI init commands, then QPI read and write phases */
`timescale 1ns/1ps
`default_nettype none
`include "psram_macros.svh"

module psram_sequencer (
	input  wire                   mem_clk,
	input  wire                   rst_n,
	input  wire                   req_valid,
	input  wire                   req_write,
	output logic                  req_done,
	output logic                  init_done,
	output logic                  timer_load,
	output logic [15:0]           timer_count,
	input  wire                   timer_zero,
	output psram_pkg::phase_e     phase,
	output psram_pkg::psram_op_e  op,
	output logic [7:0]            cmd_byte,
	output logic                  shift_load
);
	import psram_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	// SPI byte on the pins; low during the CE-high gap before it
	logic        spi_run;
	logic        spi_run_nxt;

	always_comb begin
		state_nxt   = state;
		spi_run_nxt = spi_run;
		timer_load  = 1'b0;
		timer_count = 16'd0;
		shift_load  = 1'b0;
		req_done    = 1'b0;
		phase       = PH_IDLE;
		case (state)
			ST_PWRUP: begin
				// Timer starts at the power-up delay out of reset
				if (timer_zero) begin
					state_nxt = ST_RSTEN;
				end
			end
			ST_RSTEN, ST_RST, ST_QPI_EN: begin
				if (!spi_run) begin
					// Gap cycle, load byte and bit count
					shift_load  = 1'b1;
					timer_load  = 1'b1;
					timer_count = 16'(`PSRAM_SPI_BITS - 1);
					spi_run_nxt = 1'b1;
				end else begin
					phase = PH_SPI;
					if (timer_zero) begin
						spi_run_nxt = 1'b0;
						case (state)
							ST_RSTEN: state_nxt = ST_RST;
							ST_RST:   state_nxt = ST_QPI_EN;
							default:  state_nxt = ST_IDLE;
						endcase
					end
				end
			end
			ST_IDLE: begin
				if (req_valid) begin
					shift_load  = 1'b1;
					timer_load  = 1'b1;
					timer_count = 16'(`PSRAM_CMD_NIBBLES - 1);
					state_nxt   = ST_CMD;
				end
			end
			ST_CMD: begin
				phase = PH_CMD;
				if (timer_zero) begin
					timer_load  = 1'b1;
					timer_count = 16'(`PSRAM_ADDR_NIBBLES - 1);
					state_nxt   = ST_ADDR;
				end
			end
			ST_ADDR: begin
				phase = PH_ADDR;
				if (timer_zero) begin
					timer_load = 1'b1;
					// Writes go straight to data
					if (req_write) begin
						timer_count = 16'(`PSRAM_DATA_NIBBLES - 1);
						state_nxt   = ST_DATA;
					end else begin
						timer_count = 16'(`PSRAM_WAIT_CYCLES - 1);
						state_nxt   = ST_WAIT;
					end
				end
			end
			ST_WAIT: begin
				phase = PH_WAIT;
				if (timer_zero) begin
					timer_load  = 1'b1;
					timer_count = 16'(`PSRAM_DATA_NIBBLES - 1);
					state_nxt   = ST_DATA;
				end
			end
			ST_DATA: begin
				phase = req_write ? PH_WDATA : PH_RDATA;
				if (timer_zero) begin
					state_nxt = ST_DONE;
				end
			end
			ST_DONE: begin
				// CE back high, read word already complete
				req_done  = 1'b1;
				state_nxt = ST_IDLE;
			end
			default: begin
				state_nxt = ST_PWRUP;
			end
		endcase
	end

	// Command byte and transfer kind per state
	always_comb begin
		op       = OP_NONE;
		cmd_byte = 8'h00;
		case (state)
			ST_RSTEN: begin
				op       = OP_SPI_CMD;
				cmd_byte = `PSRAM_CMD_RSTEN;
			end
			ST_RST: begin
				op       = OP_SPI_CMD;
				cmd_byte = `PSRAM_CMD_RST;
			end
			ST_QPI_EN: begin
				op       = OP_SPI_CMD;
				cmd_byte = `PSRAM_CMD_QPI_EN;
			end
			ST_IDLE, ST_CMD, ST_ADDR, ST_WAIT, ST_DATA: begin
				// Idle only counts once a request is up
				if (req_valid) begin
					op       = req_write ? OP_QWRITE : OP_QREAD;
					cmd_byte = req_write ? `PSRAM_CMD_QWRITE : `PSRAM_CMD_QREAD;
				end
			end
			default: begin
				op = OP_NONE;
			end
		endcase
	end

	always_ff @(posedge mem_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_PWRUP;
			spi_run   <= 1'b0;
			init_done <= 1'b0;
		end else begin
			state   <= state_nxt;
			spi_run <= spi_run_nxt;
			// Stays set once QPI mode is entered
			if ((state == ST_QPI_EN) && (state_nxt == ST_IDLE)) begin
				init_done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/psram_axil_slave.sv
/* AXI4-Lite slave for the PSRAM controller
   Takes one read or write at a time and holds its response until taken */
`timescale 1ns/1ps
`default_nettype none
`include "psram_macros.svh"

module psram_axil_slave (
	input  wire                      mem_clk,
	input  wire                      rst_n,
	input  wire  [31:0]              awaddr,
	input  wire                      awvalid,
	output logic                     awready,
	input  wire  [31:0]              wdata,
	input  wire                      wvalid,
	output logic                     wready,
	output logic                     bvalid,
	output logic [1:0]               bresp,
	input  wire                      bready,
	input  wire  [31:0]              araddr,
	input  wire                      arvalid,
	output logic                     arready,
	output logic                     rvalid,
	output logic [31:0]              rdata,
	output logic [1:0]               rresp,
	input  wire                      rready,
	input  wire                      init_done,
	output logic                     req_valid,
	output logic                     req_write,
	output logic [`PSRAM_ADDR_W-1:0] req_addr,
	output logic [`PSRAM_DATA_W-1:0] req_wdata,
	input  wire                      req_done,
	input  wire  [`PSRAM_DATA_W-1:0] rdata_word
);
	import psram_pkg::*;

	// Request in flight, OP_NONE when nothing pending
	psram_op_e                cur_op;
	logic [`PSRAM_DATA_W-1:0] rdata_q;
	logic                     idle;
	logic                     wr_fire;
	logic                     rd_fire;

	// Free for a new request only once init is over and no response waits
	assign idle = init_done && (cur_op == OP_NONE) && !bvalid && !rvalid;

	// AW and W are taken together
	assign awready = idle && awvalid && wvalid;
	assign wready  = awready;
	// Reads yield to any write half on offer
	assign arready = idle && !awvalid && !wvalid;

	assign wr_fire = awvalid && awready;
	assign rd_fire = arvalid && arready;

	// Request side follows the pending op
	assign req_valid = (cur_op != OP_NONE);
	assign req_write = (cur_op == OP_QWRITE);

	// Always OKAY
	assign bresp = 2'b00;
	assign rresp = 2'b00;
	// Word zero-extended onto the data bus
	assign rdata = {{(32 - `PSRAM_DATA_W){1'b0}}, rdata_q};

	always_ff @(posedge mem_clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_op <= OP_NONE;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_fire) begin
				cur_op <= OP_QWRITE;
			end else if (rd_fire) begin
				cur_op <= OP_QREAD;
			end else if (req_done) begin
				// Turn the finished request into its response
				cur_op <= OP_NONE;
				if (cur_op == OP_QWRITE) begin
					bvalid <= 1'b1;
				end else begin
					rvalid <= 1'b1;
				end
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Byte address to word address
	always_ff @(posedge mem_clk) begin
		if (wr_fire) begin
			req_addr  <= awaddr[`PSRAM_ADDR_W:1];
			req_wdata <= wdata[`PSRAM_DATA_W-1:0];
		end else if (rd_fire) begin
			req_addr <= araddr[`PSRAM_ADDR_W:1];
		end
		// Read word arrives with req_done
		if (req_done && (cur_op == OP_QREAD)) begin
			rdata_q <= rdata_word;
		end
	end

endmodule

`default_nettype wire

//--- hw/psram_ctrl_top.sv
/* Quad-SPI PSRAM controller with an AXI4-Lite slave
   Connects the AXI front end, sequencer, phase timer and pin shifter */
`timescale 1ns/1ps
`default_nettype none
`include "psram_macros.svh"

module psram_ctrl_top #(
	parameter int unsigned POWERUP_CYCLES = `PSRAM_PWRUP_DEFAULT
) (
	input  wire         mem_clk,
	input  wire         rst_n,
	// AXI4-Lite slave
	input  wire  [31:0] awaddr,
	input  wire         awvalid,
	output logic        awready,
	input  wire  [31:0] wdata,
	input  wire         wvalid,
	output logic        wready,
	output logic        bvalid,
	output logic [1:0]  bresp,
	input  wire         bready,
	input  wire  [31:0] araddr,
	input  wire         arvalid,
	output logic        arready,
	output logic        rvalid,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	input  wire         rready,
	// PSRAM pins, sio split into both directions
	output logic        mem_ce_n,
	output logic [3:0]  sio_out,
	output logic        sio_oe,
	input  wire  [3:0]  sio_in,
	output logic        init_done
);
	import psram_pkg::*;

	// Request handshake
	logic                     req_valid;
	logic                     req_write;
	logic [`PSRAM_ADDR_W-1:0] req_addr;
	logic [`PSRAM_DATA_W-1:0] req_wdata;
	logic                     req_done;
	logic [`PSRAM_DATA_W-1:0] rdata_word;
	// Timer control
	logic                     timer_load;
	logic [15:0]              timer_count;
	logic                     timer_zero;
	// Shifter control
	phase_e                   phase;
	psram_op_e                op;
	logic [7:0]               cmd_byte;
	logic                     shift_load;

	psram_axil_slave u_axil_slave (.*);

	psram_sequencer u_sequencer (.*);

	psram_cycle_timer #(
		.POWERUP_CYCLES(POWERUP_CYCLES)
	) u_cycle_timer (.*);

	psram_shifter u_shifter (.*);

endmodule

`default_nettype wire

//--- testbench/psram_model.sv
/* Behavioral quad-SPI PSRAM
   Checks the SPI init bytes and QPI framing, stores written words, returns read data */
`timescale 1ns/1ps
`default_nettype none
`include "psram_macros.svh"

module psram_model (
	input  wire         mem_clk,
	input  wire         rst_n,
	input  wire         mem_ce_n,
	input  wire  [3:0]  sio_out,
	input  wire         sio_oe,
	output logic [3:0]  sio_in,
	output logic        init_ok,
	output logic        xfer_valid,
	output logic        xfer_write,
	output logic [23:0] xfer_addr,
	output logic [15:0] xfer_data,
	output int          error_count
);

	// Storage keyed by word address
	logic [15:0] mem_q [logic [23:0]];
	// CE-low cycles seen in the current transfer
	int          cyc;
	int          init_cnt;
	logic [7:0]  spi_byte;
	logic [7:0]  cmd_q;
	logic [23:0] addr_q;
	logic [15:0] data_q;
	logic [15:0] rd_hold;
	logic [15:0] rd_word;

	initial sio_in = 4'h0;

	// Init bytes in the order the device expects
	function automatic logic [7:0] init_command(input int idx);
		case (idx)
			0:       init_command = `PSRAM_CMD_RSTEN;
			1:       init_command = `PSRAM_CMD_RST;
			default: init_command = `PSRAM_CMD_QPI_EN;
		endcase
	endfunction

	task automatic require_driven();
		if (!sio_oe) begin
			$display("%0t: controller released sio while it should drive it", $time);
			error_count = error_count + 1;
		end
	endtask

	task automatic take_spi_bit();
		require_driven();
		spi_byte = {spi_byte[6:0], sio_out[0]};
	endtask

	task automatic close_spi_command();
		if (cyc != `PSRAM_SPI_BITS) begin
			$display("%0t: SPI command held CE low for %0d cycles", $time, cyc);
			error_count = error_count + 1;
		end
		if (spi_byte != init_command(init_cnt)) begin
			$display("ERR %0t: init command %0d was %h, expected %h", $time, init_cnt,
				spi_byte, init_command(init_cnt));
			error_count = error_count + 1;
		end
		init_cnt = init_cnt + 1;
		if (init_cnt == 3) begin
			init_ok <= 1'b1;
		end
	endtask

	task automatic take_qpi_cycle();
		if (cyc <= 2) begin
			require_driven();
			cmd_q = {cmd_q[3:0], sio_out};
			if ((cyc == 2) && (cmd_q != `PSRAM_CMD_QWRITE) && (cmd_q != `PSRAM_CMD_QREAD)) begin
				$display("ERR %0t: unknown QPI command %h", $time, cmd_q);
				error_count = error_count + 1;
			end
		end else if (cyc <= 8) begin
			require_driven();
			addr_q = {addr_q[19:0], sio_out};
		end else if (cmd_q == `PSRAM_CMD_QWRITE) begin
			if (cyc <= 12) begin
				require_driven();
				data_q = {data_q[11:0], sio_out};
			end
		end else if (cmd_q == `PSRAM_CMD_QREAD) begin
			// Bus belongs to the memory in wait and data cycles
			if (sio_oe) begin
				$display("%0t: controller drove sio during read wait or data", $time);
				error_count = error_count + 1;
			end
			if (cyc == 14) begin
				rd_hold = mem_q.exists(addr_q) ? mem_q[addr_q] : 16'h0000;
				rd_word = rd_hold;
			end
			// Nibble for the next cycle, MSB first
			if ((cyc >= 14) && (cyc <= 17)) begin
				sio_in  <= rd_word[15:12];
				rd_word = {rd_word[11:0], 4'h0};
			end else begin
				sio_in <= 4'h0;
			end
		end
	endtask

	task automatic close_qpi_transfer();
		if (cmd_q == `PSRAM_CMD_QWRITE) begin
			if (cyc != 12) begin
				$display("%0t: QPI write held CE low for %0d cycles", $time, cyc);
				error_count = error_count + 1;
			end else begin
				mem_q[addr_q] = data_q;
				xfer_valid <= 1'b1;
				xfer_write <= 1'b1;
				xfer_addr  <= addr_q;
				xfer_data  <= data_q;
			end
		end else if (cmd_q == `PSRAM_CMD_QREAD) begin
			if (cyc != 18) begin
				$display("%0t: QPI read held CE low for %0d cycles", $time, cyc);
				error_count = error_count + 1;
			end else begin
				xfer_valid <= 1'b1;
				xfer_write <= 1'b0;
				xfer_addr  <= addr_q;
				xfer_data  <= rd_hold;
			end
		end
	endtask

	always @(posedge mem_clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc         = 0;
			init_cnt    = 0;
			error_count = 0;
			spi_byte    = 8'h00;
			cmd_q       = 8'h00;
			addr_q      = 24'h000000;
			data_q      = 16'h0000;
			rd_hold     = 16'h0000;
			rd_word     = 16'h0000;
			sio_in      <= 4'h0;
			init_ok     <= 1'b0;
			xfer_valid  <= 1'b0;
			xfer_write  <= 1'b0;
			xfer_addr   <= 24'h000000;
			xfer_data   <= 16'h0000;
		end else begin
			xfer_valid <= 1'b0;
			if (!mem_ce_n) begin
				cyc = cyc + 1;
				// SPI until the three init bytes are in
				if (init_cnt < 3) begin
					take_spi_bit();
				end else begin
					take_qpi_cycle();
				end
			end else if (cyc != 0) begin
				// First CE-high cycle closes the transfer
				if (init_cnt < 3) begin
					close_spi_command();
				end else begin
					close_qpi_transfer();
				end
				cyc = 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/psram_checker.sv
/* AXI4-Lite monitor for the PSRAM controller
   Keeps a word model from accepted writes and compares reads and PSRAM transfers */
`timescale 1ns/1ps
`default_nettype none

module psram_checker (
	input  wire         mem_clk,
	input  wire         rst_n,
	input  wire         init_done,
	input  wire  [31:0] awaddr,
	input  wire         awvalid,
	input  wire         awready,
	input  wire  [31:0] wdata,
	input  wire         wvalid,
	input  wire         wready,
	input  wire         bvalid,
	input  wire  [1:0]  bresp,
	input  wire         bready,
	input  wire  [31:0] araddr,
	input  wire         arvalid,
	input  wire         arready,
	input  wire         rvalid,
	input  wire  [31:0] rdata,
	input  wire  [1:0]  rresp,
	input  wire         rready,
	input  wire         mem_ce_n,
	input  wire         xfer_valid,
	input  wire         xfer_write,
	input  wire  [23:0] xfer_addr,
	input  wire  [15:0] xfer_data,
	output int          error_count
);

	// Expected contents, missing entries read as zero
	logic [15:0] mem_q [logic [23:0]];
	// Request the controller is working on
	logic        pend_valid;
	logic        pend_write;
	logic [23:0] pend_addr;
	logic [15:0] pend_data;
	logic [15:0] exp_word;
	// CE-low bursts seen, up to the three init commands
	int          init_cmds;
	// Previous-cycle values for stability checks
	logic        ce_d;
	logic        b_hold;
	logic        r_hold;
	logic [31:0] rdata_d;

	task automatic flag(input string msg);
		$display("%0t: %s", $time, msg);
		error_count = error_count + 1;
	endtask

	always @(posedge mem_clk or negedge rst_n) begin
		if (!rst_n) begin
			error_count = 0;
			pend_valid  = 1'b0;
			pend_write  = 1'b0;
			pend_addr   = 24'h000000;
			pend_data   = 16'h0000;
			exp_word    = 16'h0000;
			init_cmds   = 0;
			ce_d        = 1'b1;
			b_hold      = 1'b0;
			r_hold      = 1'b0;
			rdata_d     = 32'h0;
		end else begin
			// An init command ends when CE goes back high
			if (!ce_d && mem_ce_n && (init_cmds < 3)) begin
				init_cmds = init_cmds + 1;
			end
			if ((init_cmds < 3) && (init_done || awready || wready || arready)) begin
				flag("init_done or a ready raised before the three init commands");
			end
			if ((init_cmds == 3) && !init_done) begin
				flag("init_done low after the three init commands");
			end
			if (arready && awvalid && wvalid) begin
				flag("read accepted while a write was offered");
			end
			if ((awvalid && awready) != (wvalid && wready)) begin
				flag("AW and W not accepted together");
			end
			if ((bvalid || rvalid) && (awready || arready)) begin
				flag("new request accepted with a response pending");
			end
			if (ce_d && !mem_ce_n && (bvalid || rvalid)) begin
				flag("PSRAM access started while a response waits");
			end
			if (bvalid && (bresp != 2'b00)) begin
				$display("ERR %0t: bresp %b, expected OKAY", $time, bresp);
				error_count = error_count + 1;
			end
			if (rvalid && (rresp != 2'b00)) begin
				$display("ERR %0t: rresp %b, expected OKAY", $time, rresp);
				error_count = error_count + 1;
			end
			// Responses hold under back-pressure
			if (b_hold && !bvalid) begin
				flag("bvalid dropped before bready");
			end
			if (r_hold && (!rvalid || (rdata != rdata_d))) begin
				flag("read response changed before rready");
			end
			// PSRAM transfer must match the accepted request
			if (xfer_valid) begin
				if (!pend_valid) begin
					flag("PSRAM transfer without an AXI request");
				end else if ((xfer_write != pend_write) || (xfer_addr != pend_addr)) begin
					$display("ERR %0t: PSRAM %s at %h, expected %s at %h", $time,
						xfer_write ? "write" : "read", xfer_addr,
						pend_write ? "write" : "read", pend_addr);
					error_count = error_count + 1;
				end else if (pend_write && (xfer_data != pend_data)) begin
					$display("ERR %0t: PSRAM write data %h, expected %h", $time,
						xfer_data, pend_data);
					error_count = error_count + 1;
				end else if (!pend_write && (xfer_data != exp_word)) begin
					$display("ERR %0t: PSRAM held %h at %h, expected %h", $time,
						xfer_data, xfer_addr, exp_word);
					error_count = error_count + 1;
				end
				pend_valid = 1'b0;
			end
			if (awvalid && awready) begin
				mem_q[awaddr[24:1]] = wdata[15:0];
				pend_valid = 1'b1;
				pend_write = 1'b1;
				pend_addr  = awaddr[24:1];
				pend_data  = wdata[15:0];
			end
			if (arvalid && arready) begin
				exp_word   = mem_q.exists(araddr[24:1]) ? mem_q[araddr[24:1]] : 16'h0000;
				pend_valid = 1'b1;
				pend_write = 1'b0;
				pend_addr  = araddr[24:1];
			end
			if (rvalid && rready && (rdata != {16'h0000, exp_word})) begin
				$display("ERR %0t: read at %h returned %h, expected %h", $time, pend_addr,
					rdata, {16'h0000, exp_word});
				error_count = error_count + 1;
			end
			b_hold  = bvalid && !bready;
			r_hold  = rvalid && !rready;
			rdata_d = rdata;
			ce_d    = mem_ce_n;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_psram_ctrl.sv
/* Testbench for the quad-SPI PSRAM controller
   Random AXI4-Lite reads and writes against a PSRAM model, with back-pressure */
`timescale 1ns/1ps
`default_nettype none

module tb_psram_ctrl;

	localparam int TIMEOUT   = 2000;
	// Events the stimulus waits on
	localparam int EV_AW     = 0;
	localparam int EV_B      = 1;
	localparam int EV_BVALID = 2;
	localparam int EV_AR     = 3;
	localparam int EV_R      = 4;
	localparam int EV_RVALID = 5;

	logic        mem_clk = 1'b0;
	logic        rst_n   = 1'b0;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic        bvalid;
	logic [1:0]  bresp;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic        rvalid;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rready;
	logic        mem_ce_n;
	logic [3:0]  sio_out;
	logic        sio_oe;
	logic [3:0]  sio_in;
	logic        init_done;
	logic        model_init_ok;
	logic        xfer_valid;
	logic        xfer_write;
	logic [23:0] xfer_addr;
	logic [15:0] xfer_data;
	int          model_errors;
	int          checker_errors;
	int          tb_errors;
	logic        stop_run;
	// Small address set so reads hit earlier writes
	logic [23:0] addr_tbl [16];

	always #2 mem_clk = ~mem_clk;

	psram_ctrl_top #(
		.POWERUP_CYCLES(64)
	) DUT (.*);

	psram_model u_model (
		.mem_clk    (mem_clk),
		.rst_n      (rst_n),
		.mem_ce_n   (mem_ce_n),
		.sio_out    (sio_out),
		.sio_oe     (sio_oe),
		.sio_in     (sio_in),
		.init_ok    (model_init_ok),
		.xfer_valid (xfer_valid),
		.xfer_write (xfer_write),
		.xfer_addr  (xfer_addr),
		.xfer_data  (xfer_data),
		.error_count(model_errors)
	);

	psram_checker u_checker (
		.error_count(checker_errors),
		.*
	);

	// Condition as sampled at the current rising edge
	function automatic logic event_seen(input int which);
		case (which)
			EV_AW:     event_seen = awvalid && awready;
			EV_B:      event_seen = bvalid && bready;
			EV_BVALID: event_seen = bvalid;
			EV_AR:     event_seen = arvalid && arready;
			EV_R:      event_seen = rvalid && rready;
			default:   event_seen = rvalid;
		endcase
	endfunction

	task automatic wait_for_event(input int which, input string what);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && !stop_run) begin
			@(posedge mem_clk);
			seen = event_seen(which);
			n    = n + 1;
			if (!seen && (n >= TIMEOUT)) begin
				$display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
				tb_errors = tb_errors + 1;
				stop_run  = 1'b1;
			end
		end
	endtask

	// order 0 offers AW and W together, 1 AW first, 2 W first
	task automatic write_word(input logic [23:0] word_addr, input logic [15:0] data,
			input int order, input int stall);
		logic [31:0] r;
		int          gap;
		r   = $urandom;
		gap = 1 + int'(r[1:0]);
		if (!stop_run) begin
			@(posedge mem_clk);
			// Bits outside the word address and data are ignored
			awaddr <= {r[15:9], word_addr, r[8]};
			wdata  <= {r[31:16], data};
			bready <= (stall == 0);
			if (order != 2) begin
				awvalid <= 1'b1;
			end
			if (order != 1) begin
				wvalid <= 1'b1;
			end
			if (order != 0) begin
				repeat (gap) @(posedge mem_clk);
				awvalid <= 1'b1;
				wvalid  <= 1'b1;
			end
			wait_for_event(EV_AW, "AW/W handshake");
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			if (stall > 0) begin
				wait_for_event(EV_BVALID, "bvalid");
				// Hold off B with a read of the same word on offer
				araddr  <= awaddr;
				arvalid <= 1'b1;
				rready  <= 1'b1;
				repeat (stall) @(posedge mem_clk);
				bready <= 1'b1;
				wait_for_event(EV_B, "B handshake");
				bready <= 1'b0;
				wait_for_event(EV_AR, "AR handshake after B");
				arvalid <= 1'b0;
				wait_for_event(EV_R, "R handshake after B");
				rready <= 1'b0;
			end else begin
				wait_for_event(EV_B, "B handshake");
				bready <= 1'b0;
			end
		end
	endtask

	task automatic read_word(input logic [23:0] word_addr, input int stall);
		logic [31:0] r;
		r = $urandom;
		if (!stop_run) begin
			@(posedge mem_clk);
			araddr  <= {r[15:9], word_addr, r[8]};
			arvalid <= 1'b1;
			rready  <= (stall == 0);
			wait_for_event(EV_AR, "AR handshake");
			arvalid <= 1'b0;
			if (stall > 0) begin
				wait_for_event(EV_RVALID, "rvalid");
				// Hold off R with a write to the same word on offer
				awaddr  <= araddr;
				wdata   <= {r[15:0], r[31:16]};
				awvalid <= 1'b1;
				wvalid  <= 1'b1;
				bready  <= 1'b1;
				repeat (stall) @(posedge mem_clk);
				rready <= 1'b1;
				wait_for_event(EV_R, "R handshake");
				rready <= 1'b0;
				wait_for_event(EV_AW, "AW/W handshake after R");
				awvalid <= 1'b0;
				wvalid  <= 1'b0;
				wait_for_event(EV_B, "B handshake after R");
				bready <= 1'b0;
			end else begin
				wait_for_event(EV_R, "R handshake");
				rready <= 1'b0;
			end
		end
	endtask

	initial begin
		int          i;
		int          n;
		int          order;
		int          stall;
		logic [31:0] r;
		void'($urandom(21542));
		awaddr    = 32'h0;
		awvalid   = 1'b0;
		wdata     = 32'h0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = 32'h0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		tb_errors = 0;
		stop_run  = 1'b0;
		// Top nibble keeps the 16 addresses distinct
		for (i = 0; i < 16; i++) begin
			r           = $urandom;
			addr_tbl[i] = {i[3:0], r[19:0]};
		end
		repeat (8) @(posedge mem_clk);
		rst_n <= 1'b1;

		// Write and read both offered during init, write goes first
		@(posedge mem_clk);
		awaddr  <= {7'h00, addr_tbl[0], 1'b0};
		wdata   <= 32'h0000_a5c3;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		araddr  <= {7'h00, addr_tbl[1], 1'b0};
		arvalid <= 1'b1;
		bready  <= 1'b1;
		rready  <= 1'b1;
		wait_for_event(EV_AW, "first write after init");
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		wait_for_event(EV_B, "first write response");
		// Never-written address, reads zero
		wait_for_event(EV_AR, "first read");
		arvalid <= 1'b0;
		wait_for_event(EV_R, "first read response");
		bready <= 1'b0;
		rready <= 1'b0;

		// Split AW and W in both orders
		write_word(addr_tbl[5], 16'h1234, 1, 0);
		read_word(addr_tbl[5], 0);
		write_word(addr_tbl[6], 16'hbeef, 2, 3);
		read_word(addr_tbl[6], 2);

		// Random mix, a quarter of responses back-pressured
		for (n = 0; n < 200; n++) begin
			r     = $urandom;
			stall = (r[1:0] == 2'b00) ? 1 + int'(r[5:2]) : 0;
			order = int'(r[7:6]) % 3;
			if (r[8]) begin
				write_word(addr_tbl[r[12:9]], r[31:16], order, stall);
			end else begin
				read_word(addr_tbl[r[12:9]], stall);
			end
		end

		repeat (4) @(posedge mem_clk);
		if (!model_init_ok) begin
			$display("PSRAM model never saw the full init sequence");
			tb_errors = tb_errors + 1;
		end
		$display("Errors: testbench %0d, checker %0d, model %0d", tb_errors, checker_errors,
			model_errors);
		if ((tb_errors + checker_errors + model_errors) == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hw/psram_pkg.sv
hw/psram_cycle_timer.sv
hw/psram_shifter.sv
hw/psram_sequencer.sv
hw/psram_axil_slave.sv
hw/psram_ctrl_top.sv
testbench/psram_model.sv
testbench/psram_checker.sv
testbench/tb_psram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build the PSRAM controller testbench with Verilator and run it.
# Success is decided by the pass line in the simulator output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_psram_ctrl -f vlog.f \
	&& ./obj_dir/Vtb_psram_ctrl | tee /dev/stderr | grep -q "^Test OK$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
